// File: logic/pio_pkg.sv
// PIO fabric shared definitions

`default_nettype none

package pio_pkg;

        // ##############################
        // Bus widths and address fields
        // ##############################
        localparam int pio_data_w = 32;   // APB data and broadcast bus
        localparam int pio_addr_w = 16;   // APB address

        localparam int node_id_lsb = 12;
        localparam int node_id_msb = 15;
        localparam int reg_idx_lsb = 2;
        localparam int reg_idx_msb = 3;

        localparam int time_node_id = 15; // Reads the time counter

        // ##############################
        // Enumerated types
        // ##############################
        typedef enum logic {
                op_read  = 1'b0,
                op_write = 1'b1
        } pio_op_t;

        typedef enum logic [2:0] {
                st_idle,
                st_addr,
                st_data,
                st_wait,
                st_done
        } bridge_state_t;

endpackage

`default_nettype wire

// File: logic/pio_bridge.sv
// APB to PIO bridge

`timescale 1ns/1ps
`default_nettype none

module pio_bridge #(
        parameter int num_nodes     = 4,
        parameter int time_prescale = 3
) (
        input  wire                                 clk,
        input  wire                                 arst_n,
        input  wire                                 psel,
        input  wire                                 penable,
        input  wire                                 pwrite,
        input  wire  [pio_pkg::pio_addr_w-1:0]      paddr,
        input  wire  [pio_pkg::pio_data_w-1:0]      pwdata,
        output logic [pio_pkg::pio_data_w-1:0]      prdata,
        output logic                                pready,
        output logic                                pslverr,
        output logic                                pio_start,
        output pio_pkg::pio_op_t                    pio_rw,
        output logic [pio_pkg::pio_data_w-1:0]      pio_addr_wdata,
        input  wire                                 done,
        input  wire  [pio_pkg::pio_data_w-1:0]      done_rdata
);

        import pio_pkg::*;

        bridge_state_t                          state;
        logic [node_id_msb-node_id_lsb:0]       req_id;
        logic                                   access;
        logic                                   is_time;
        logic                                   node_ok;
        logic [time_prescale-1:0]               pre_cnt;
        logic [pio_data_w-1:0]                  time_cnt;

        assign access  = psel & penable;
        assign req_id  = paddr[node_id_msb:node_id_lsb];
        assign is_time = (int'(req_id) == time_node_id);
        assign node_ok = (int'(req_id) < num_nodes);

        // ##############################
        // Free-running time counter
        // ##############################
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        pre_cnt  <= '0;
                        time_cnt <= '0;
                end else begin
                        pre_cnt <= pre_cnt + 1'b1;
                        if (&pre_cnt)
                                time_cnt <= time_cnt + 1'b1;
                end
        end

        // ##############################
        // Transfer FSM
        // ##############################
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        state     <= st_idle;
                        pio_start <= 1'b0;
                        pready    <= 1'b0;
                        pslverr   <= 1'b0;
                end else begin
                        case (state)
                                st_idle: if (access) begin
                                        if (is_time) begin
                                                pready  <= 1'b1;
                                                pslverr <= pwrite;  // Counter is read-only
                                                state   <= st_done;
                                        end else if (!node_ok) begin
                                                pready  <= 1'b1;
                                                pslverr <= 1'b1;
                                                state   <= st_done;
                                        end else begin
                                                pio_start <= 1'b1;  // Address beat
                                                state     <= st_addr;
                                        end
                                end
                                st_addr: begin
                                        pio_start <= (pio_rw == op_write);  // Data beat
                                        state     <= (pio_rw == op_write) ? st_data : st_wait;
                                end
                                st_data: begin
                                        pio_start <= 1'b0;
                                        state     <= st_wait;
                                end
                                st_wait: if (done) begin
                                        pready  <= 1'b1;
                                        pslverr <= 1'b0;
                                        state   <= st_done;
                                end
                                st_done: begin
                                        pready  <= 1'b0;
                                        pslverr <= 1'b0;
                                        state   <= st_idle;
                                end
                                default: state <= st_idle;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (state == st_idle && access) begin
                        pio_rw         <= pwrite ? op_write : op_read;
                        pio_addr_wdata <= pio_data_w'(paddr);
                        prdata         <= time_cnt;
                end else if (state == st_addr) begin
                        pio_addr_wdata <= pwdata;
                end else if (state == st_wait && done) begin
                        prdata <= done_rdata;
                end
        end

        // A node answer only comes back for a transfer in flight
        assert property (@(posedge clk) disable iff (!arst_n) done |-> state != st_idle);

endmodule

`default_nettype wire

// File: logic/pio_node.sv
// PIO peripheral node

`timescale 1ns/1ps
`default_nettype none

module pio_node #(
        parameter int node_id = 0,
        parameter int div     = 2
) (
        input  wire                             clk,
        input  wire                             arst_n,
        input  wire                             pio_start,
        input  wire  pio_pkg::pio_op_t          pio_rw,
        input  wire  [pio_pkg::pio_data_w-1:0]  pio_addr_wdata,
        output logic                            tick,
        output logic                            ack,
        output logic                            rvalid,
        output logic [pio_pkg::pio_data_w-1:0]  rdata
);

        import pio_pkg::*;

        localparam int cnt_w = $clog2(div + 1);

        logic [cnt_w-1:0]               div_cnt;
        logic                           data_beat;      // Next beat carries write data
        logic                           hit;
        logic                           addr_hit;
        logic                           pend_valid;
        pio_op_t                        pend_rw;
        logic [1:0]                     pend_idx;
        logic [pio_data_w-1:0]          pend_wdata;
        logic                           exec;
        logic                           ack_next;
        logic                           rvalid_next;
        logic [pio_data_w-1:0]          wr_count;
        logic [pio_data_w-1:0]          reg_file [0:2];

        assign tick     = (div_cnt == cnt_w'(div - 1));
        assign addr_hit = (pio_addr_wdata[node_id_msb:node_id_lsb] == 4'(node_id));
        assign exec     = tick & pend_valid;

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n)
                        div_cnt <= '0;
                else
                        div_cnt <= tick ? '0 : div_cnt + 1'b1;
        end

        // ##############################
        // Beat decoder and execution
        // ##############################
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        data_beat   <= 1'b0;
                        hit         <= 1'b0;
                        pend_valid  <= 1'b0;
                        pend_rw     <= op_read;
                        ack_next    <= 1'b0;
                        rvalid_next <= 1'b0;
                        ack         <= 1'b0;
                        rvalid      <= 1'b0;
                        wr_count    <= '0;
                end else begin
                        if (pio_start) begin
                                if (!data_beat) begin
                                        data_beat <= (pio_rw == op_write);  // Every node tracks beats
                                        hit       <= addr_hit;
                                        if (addr_hit) begin
                                                pend_rw    <= pio_rw;
                                                pend_valid <= (pio_rw == op_read);
                                        end
                                end else begin
                                        data_beat <= 1'b0;
                                        if (hit)
                                                pend_valid <= 1'b1;
                                end
                        end
                        if (tick) begin
                                ack         <= ack_next;        // Held one tick period
                                rvalid      <= rvalid_next;
                                ack_next    <= exec && (pend_rw == op_write);
                                rvalid_next <= exec && (pend_rw == op_read);
                                if (exec)
                                        pend_valid <= 1'b0;
                                if (exec && pend_rw == op_write)
                                        wr_count <= wr_count + 1'b1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (pio_start && !data_beat && addr_hit)
                        pend_idx <= pio_addr_wdata[reg_idx_msb:reg_idx_lsb];
                if (pio_start && data_beat && hit)
                        pend_wdata <= pio_addr_wdata;
                if (exec) begin
                        if (pend_rw == op_write && pend_idx != 2'd3)
                                reg_file[pend_idx] <= pend_wdata;       // Register 3 is read-only
                        if (pend_rw == op_read)
                                rdata <= (pend_idx == 2'd3) ? wr_count : reg_file[pend_idx];
                end
        end

        assert property (@(posedge clk) disable iff (!arst_n) !(ack && rvalid));

endmodule

`default_nettype wire

// File: logic/pio_collect.sv
// PIO response collector

`timescale 1ns/1ps
`default_nettype none

module pio_collect #(
        parameter int num_nodes = 4
) (
        input  wire                                             clk,
        input  wire                                             arst_n,
        input  wire  [num_nodes-1:0]                            node_tick,
        input  wire  [num_nodes-1:0]                            node_ack,
        input  wire  [num_nodes-1:0]                            node_rvalid,
        input  wire  [num_nodes-1:0][pio_pkg::pio_data_w-1:0]   node_rdata,
        output logic                                            done,
        output logic [pio_pkg::pio_data_w-1:0]                  done_rdata
);

        import pio_pkg::*;

        logic [num_nodes-1:0]                   lat_ack;
        logic [num_nodes-1:0]                   lat_rvalid;
        logic [num_nodes-1:0][pio_data_w-1:0]   lat_rdata;
        logic                                   sel_valid;
        logic [pio_data_w-1:0]                  sel_rdata;
        logic                                   ans_flag;
        logic                                   ans_flag_d;
        logic [pio_data_w-1:0]                  ans_rdata;

        // ##############################
        // Per-node latches
        // ##############################
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        lat_ack    <= '0;
                        lat_rvalid <= '0;
                end else begin
                        for (int i = 0; i < num_nodes; i++) begin
                                if (node_tick[i]) begin
                                        lat_ack[i]    <= node_ack[i];
                                        lat_rvalid[i] <= node_rvalid[i];
                                end
                        end
                end
        end

        always_ff @(posedge clk) begin
                for (int i = 0; i < num_nodes; i++)
                        if (node_tick[i])
                                lat_rdata[i] <= node_rdata[i];
        end

        // Lowest node wins
        always_comb begin
                sel_valid = 1'b0;
                sel_rdata = '0;
                for (int i = num_nodes - 1; i >= 0; i--) begin
                        if (lat_ack[i] || lat_rvalid[i]) begin
                                sel_valid = 1'b1;
                                sel_rdata = lat_rdata[i];
                        end
                end
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        ans_flag   <= 1'b0;
                        ans_flag_d <= 1'b0;
                end else begin
                        ans_flag   <= sel_valid;
                        ans_flag_d <= ans_flag;
                end
        end

        always_ff @(posedge clk)
                ans_rdata <= sel_rdata;

        assign done       = ans_flag & ~ans_flag_d;    // Rising edge only
        assign done_rdata = ans_rdata;

        assert property (@(posedge clk) disable iff (!arst_n) $onehot0(lat_ack | lat_rvalid));

endmodule

`default_nettype wire

// File: logic/pio_subsystem.sv
// PIO subsystem top level

`timescale 1ns/1ps
`default_nettype none

module pio_subsystem #(
        parameter int num_nodes     = 4,
        parameter int base_div      = 2,
        parameter int time_prescale = 3
) (
        input  wire                             clk,
        input  wire                             arst_n,
        input  wire                             psel,
        input  wire                             penable,
        input  wire                             pwrite,
        input  wire  [pio_pkg::pio_addr_w-1:0]  paddr,
        input  wire  [pio_pkg::pio_data_w-1:0]  pwdata,
        output wire  [pio_pkg::pio_data_w-1:0]  prdata,
        output wire                             pready,
        output wire                             pslverr
);

        import pio_pkg::*;

        logic                                   pio_start;
        pio_op_t                                pio_rw;
        logic [pio_data_w-1:0]                  pio_addr_wdata;
        logic [num_nodes-1:0]                   node_tick;
        logic [num_nodes-1:0]                   node_ack;
        logic [num_nodes-1:0]                   node_rvalid;
        logic [num_nodes-1:0][pio_data_w-1:0]   node_rdata;
        logic                                   done;
        logic [pio_data_w-1:0]                  done_rdata;

        pio_bridge #(
                .num_nodes      (num_nodes),
                .time_prescale  (time_prescale)
        ) u_bridge (
                .clk            (clk),
                .arst_n         (arst_n),
                .psel           (psel),
                .penable        (penable),
                .pwrite         (pwrite),
                .paddr          (paddr),
                .pwdata         (pwdata),
                .prdata         (prdata),
                .pready         (pready),
                .pslverr        (pslverr),
                .pio_start      (pio_start),
                .pio_rw         (pio_rw),
                .pio_addr_wdata (pio_addr_wdata),
                .done           (done),
                .done_rdata     (done_rdata)
        );

        // Node i runs at clk / (base_div + i)
        for (genvar gi = 0; gi < num_nodes; gi++) begin : g_node
                pio_node #(
                        .node_id        (gi),
                        .div            (base_div + gi)
                ) u_node (
                        .clk            (clk),
                        .arst_n         (arst_n),
                        .pio_start      (pio_start),
                        .pio_rw         (pio_rw),
                        .pio_addr_wdata (pio_addr_wdata),
                        .tick           (node_tick[gi]),
                        .ack            (node_ack[gi]),
                        .rvalid         (node_rvalid[gi]),
                        .rdata          (node_rdata[gi])
                );
        end

        pio_collect #(
                .num_nodes      (num_nodes)
        ) u_collect (
                .clk            (clk),
                .arst_n         (arst_n),
                .node_tick      (node_tick),
                .node_ack       (node_ack),
                .node_rvalid    (node_rvalid),
                .node_rdata     (node_rdata),
                .done           (done),
                .done_rdata     (done_rdata)
        );

endmodule

`default_nettype wire

// File: test/tb_clock.sv
// Testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
        parameter int period_ns    = 8,
        parameter int reset_cycles = 2
) (
        output logic clk,
        output logic arst_n
);

        initial begin
                clk = 1'b0;
                forever #(period_ns / 2) clk = ~clk;
        end

        initial begin
                arst_n = 1'b0;
                repeat (reset_cycles) @(posedge clk);
                #1;
                arst_n = 1'b1;  // Release just after an edge
        end

endmodule

`default_nettype wire

// File: test/pio_tb.sv
// PIO subsystem testbench

`timescale 1ns/1ps
`default_nettype none

module pio_tb;

        import pio_pkg::*;

        localparam int num_nodes     = 4;
        localparam int base_div      = 2;
        localparam int time_prescale = 3;
        localparam int max_lines     = 64;

        logic                   clk;
        logic                   arst_n;
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [pio_addr_w-1:0]  paddr;
        logic [pio_data_w-1:0]  pwdata;
        wire  [pio_data_w-1:0]  prdata;
        wire                    pready;
        wire                    pslverr;

        // Transfer table loaded from the data file
        logic [8*24-1:0]        t_name  [0:max_lines-1];
        logic [7:0]             t_op    [0:max_lines-1];
        logic [pio_addr_w-1:0]  t_addr  [0:max_lines-1];
        logic [pio_data_w-1:0]  t_wdata [0:max_lines-1];
        logic [pio_data_w-1:0]  t_rdata [0:max_lines-1];
        logic                   t_err   [0:max_lines-1];
        int                     n_lines = 0;
        logic                   loaded  = 1'b0;

        tb_clock #(
                .period_ns      (8),
                .reset_cycles   (2)
        ) u_clock (
                .clk            (clk),
                .arst_n         (arst_n)
        );

        pio_subsystem #(
                .num_nodes      (num_nodes),
                .base_div       (base_div),
                .time_prescale  (time_prescale)
        ) i_dut (
                .clk            (clk),
                .arst_n         (arst_n),
                .psel           (psel),
                .penable        (penable),
                .pwrite         (pwrite),
                .paddr          (paddr),
                .pwdata         (pwdata),
                .prdata         (prdata),
                .pready         (pready),
                .pslverr        (pslverr)
        );

        // ##############################
        // Helpers
        // ##############################
        task automatic abort_run(input string why);
                $display("%s", why);
                $display("Test failed");
                $fatal(1, "run aborted");
        endtask

        task automatic check_value(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
                if (expected !== actual) begin
                        $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
                        $display("Test failed");
                        $fatal(1, "value check failed");
                end
        endtask

        task automatic load_table();
                int                     fd;
                int                     cnt;
                int                     err;
                logic [8*24-1:0]        tok;
                logic [8*120-1:0]       rest;
                logic [7:0]             op;
                logic [pio_addr_w-1:0]  addr;
                logic [pio_data_w-1:0]  wdata;
                logic [pio_data_w-1:0]  rdata;
                fd = $fopen("test/pio_testdata.txt", "r");
                if (fd == 0)
                        abort_run("Could not open the data file test/pio_testdata.txt");
                cnt = $fscanf(fd, "%s", tok);
                while (cnt == 1) begin
                        if (tok == "#") begin
                                cnt = $fgets(rest, fd);         // Skip comment line
                        end else begin
                                cnt = $fscanf(fd, "%s %h %h %h %d", op, addr, wdata, rdata, err);
                                if (cnt != 5)
                                        abort_run("A line of the data file is incomplete");
                                if (op != "W" && op != "R" && op != "T")
                                        abort_run("The data file holds an unknown operation");
                                if (n_lines == max_lines)
                                        abort_run("The data file holds too many transfers");
                                t_name[n_lines]  = tok;
                                t_op[n_lines]    = op;
                                t_addr[n_lines]  = addr;
                                t_wdata[n_lines] = wdata;
                                t_rdata[n_lines] = rdata;
                                t_err[n_lines]   = (err != 0);
                                n_lines++;
                        end
                        cnt = $fscanf(fd, "%s", tok);
                end
                $fclose(fd);
                if (n_lines == 0)
                        abort_run("The data file holds no transfers");
        endtask

        task automatic apb_transfer(input logic wr, input logic [pio_addr_w-1:0] addr,
                                    input logic [pio_data_w-1:0] wdata,
                                    output logic [pio_data_w-1:0] rdata, output logic err);
                psel    = 1'b1;         // Setup phase
                penable = 1'b0;
                pwrite  = wr;
                paddr   = addr;
                pwdata  = wdata;
                @(posedge clk);
                #1;
                penable = 1'b1;
                @(posedge clk);
                #1;
                while (!pready) begin
                        @(posedge clk);
                        #1;
                end
                rdata = prdata;
                err   = pslverr;
                @(posedge clk);         // Transfer ends on this edge
                #1;
                psel    = 1'b0;
                penable = 1'b0;
                pwrite  = 1'b0;
        endtask

        task automatic idle_gap();
                int unsigned gap;
                gap = $urandom % 4;
                repeat (gap) begin
                        @(posedge clk);
                        #1;
                end
        endtask

        // ##############################
        // Main sequence
        // ##############################
        initial begin
                logic [pio_data_w-1:0]  rd;
                logic                   err;
                logic [pio_data_w-1:0]  last_time;
                logic [pio_data_w-1:0]  rise;
                string                  name;
                psel      = 1'b0;
                penable   = 1'b0;
                pwrite    = 1'b0;
                paddr     = '0;
                pwdata    = '0;
                last_time = '0;
                void'($urandom(32'h3554));
                load_table();
                loaded = 1'b1;
                wait (arst_n === 1'b1);
                @(posedge clk);
                #1;
                for (int i = 0; i < n_lines; i++) begin
                        name = string'(t_name[i]);
                        apb_transfer(t_op[i] == "W", t_addr[i], t_wdata[i], rd, err);
                        check_value({name, " pslverr"}, 32'(t_err[i]), 32'(err));
                        if (t_op[i] == "R" && !t_err[i]) begin
                                check_value(name, t_rdata[i], rd);
                        end else if (t_op[i] == "T") begin
                                // Data column holds the minimum rise since the last T
                                if (rd < last_time)
                                        check_value({name, " time order"}, last_time, rd);
                                rise = rd - last_time;
                                if (rise < t_rdata[i])
                                        check_value({name, " time rise"}, t_rdata[i], rise);
                                last_time = rd;
                        end
                        idle_gap();
                end
                $display("Test passed");
                $finish;
        end

        // Watchdog
        initial begin
                int unsigned limit;
                wait (loaded);
                limit = n_lines * 32 * (base_div + num_nodes);
                repeat (limit) @(posedge clk);
                $display("Timeout: the transfers did not finish within %0d clock cycles", limit);
                $display("Test failed");
                $fatal(1, "watchdog expired");
        end

endmodule

`default_nettype wire

// File: test/pio_testdata.txt
# name op(W/R/T) addr wdata exp_rdata exp_pslverr
# for T lines exp_rdata is the minimum rise of the time counter since the previous T line
t_start T F000 00000000 00000000 0
n0_w0 W 0000 A0A00000 00000000 0
n1_w0 W 1000 B1B10000 00000000 0
n2_w0 W 2000 C2C20000 00000000 0
n3_w0 W 3000 D3D30000 00000000 0
n0_r0 R 0000 00000000 A0A00000 0
n1_r0 R 1000 00000000 B1B10000 0
n2_r0 R 2000 00000000 C2C20000 0
n3_r0 R 3000 00000000 D3D30000 0
n0_w1 W 0004 A0A00001 00000000 0
n1_w2 W 1008 B1B10002 00000000 0
n2_w1 W 2004 C2C20001 00000000 0
n3_w2 W 3008 D3D30002 00000000 0
n3_r2 R 3008 00000000 D3D30002 0
n2_r1 R 2004 00000000 C2C20001 0
n1_r2 R 1008 00000000 B1B10002 0
n0_r1 R 0004 00000000 A0A00001 0
n1_r0b R 1000 00000000 B1B10000 0
n2_w3 W 200C 12345678 00000000 0
n2_r3 R 200C 00000000 00000003 0
n2_r0b R 2000 00000000 C2C20000 0
n0_r3 R 000C 00000000 00000002 0
t_mid T F000 00000000 00000001 0
bad4_w W 4000 DEADBEEF 00000000 1
bad9_r R 9010 00000000 00000000 1
time_w W F000 00000055 00000000 1
n3_r3 R 300C 00000000 00000002 0
n1_w1 W 1004 B1B10001 00000000 0
n1_r1 R 1004 00000000 B1B10001 0
n1_r3 R 100C 00000000 00000003 0
t_end T F000 00000000 00000001 0

// File: sim.f
logic/pio_pkg.sv
logic/pio_bridge.sv
logic/pio_node.sv
logic/pio_collect.sv
logic/pio_subsystem.sv
test/tb_clock.sv
test/pio_tb.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the PIO testbench
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module pio_tb -f sim.f -o pio_sim

out=$(./obj_dir/pio_sim || true)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
        exit 0
else
        exit 1
fi
